//--- soc_pkg.sv
package soc_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [7:0] byte_t;
    typedef logic [15:0] prng_state_t;

    // system reset length after the last active source
    localparam int unsigned RESET_HOLD_CYCLES = 16;
    localparam int unsigned RESET_CNT_BITS = $clog2(RESET_HOLD_CYCLES);
    localparam logic [RESET_CNT_BITS-1:0] RESET_RELOAD =
        RESET_CNT_BITS'(RESET_HOLD_CYCLES - 1);

    // address windows, an address hits when (adr & mask) == base
    // 0xFFFFF000 - 0xFFFFF7FF
    localparam addr_t ROM_BASE = 32'hFFFF_F000;
    localparam addr_t ROM_MASK = 32'hFFFF_F800;

    // 0xFFFFFExx
    localparam addr_t PRNG_BASE = 32'hFFFF_FE00;
    localparam addr_t PRNG_MASK = 32'hFFFF_FF00;

    // 0xFFFFFFFx
    localparam addr_t LED_BASE = 32'hFFFF_FFF0;
    localparam addr_t LED_MASK = 32'hFFFF_FFF0;

    // former video window, 0xFFFF0000 - 0xFFFF1FFF
    localparam addr_t RSV_VIDEO_BASE = 32'hFFFF_0000;
    localparam addr_t RSV_VIDEO_MASK = 32'hFFFF_E000;

    // 0xFFFFF8xx up to 0xFFFFFFEx
    // overlaps prng and led, so it must be matched after them
    localparam addr_t RSV_IO_BASE = 32'hFFFF_F800;
    localparam addr_t RSV_IO_MASK = 32'hFFFF_F800;

    // memory sizes
    localparam int unsigned ROM_WORDS = 32;
    localparam int unsigned ROM_ADDR_BITS = $clog2(ROM_WORDS);
    localparam int unsigned RAM_ADDR_BITS = 12;

    // lfsr state after reset and feedback taps 15, 13, 12, 10
    localparam prng_state_t PRNG_SEED_DEFAULT = 16'hACE1;
    localparam prng_state_t PRNG_TAPS = 16'hB400;

endpackage

//--- reset_sequencer.sv
`timescale 1ns/1ns

module reset_sequencer (
    input  logic clk,
    input  logic reset_i,
    input  logic reset_button_n_i,
    input  logic uart_rts_n_i,
    output logic sys_reset_o
);
    import soc_pkg::*;

    logic                      src_active;
    logic [RESET_CNT_BITS-1:0] hold_cnt;

    // button and uart rts are both active low
    assign src_active = reset_i | ~reset_button_n_i | ~uart_rts_n_i;

    // block rams need some settling time after configuration,
    // so every source restarts the full hold period
    always_ff @(posedge clk) begin
        if (src_active) begin
            hold_cnt    <= RESET_RELOAD;
            sys_reset_o <= 1'b1;
        end else if (hold_cnt != '0) begin
            hold_cnt    <= hold_cnt - 1'b1;
            sys_reset_o <= 1'b1;
        end else begin
            // count ran out, release
            sys_reset_o <= 1'b0;
        end
    end

endmodule

//--- bus_address_decoder.sv
`timescale 1ns/1ns

module bus_address_decoder (
    input  logic           clk,
    input  logic           sys_reset_i,
    input  soc_pkg::addr_t wb_adr_i,
    input  logic           wb_stb_i,
    output soc_pkg::byte_t wb_dat_o,
    output logic           wb_ack_o,
    output logic           rom_stb_o,
    output logic           led_stb_o,
    output logic           prng_stb_o,
    output logic           ram_stb_o,
    input  soc_pkg::byte_t rom_dat_i,
    input  soc_pkg::byte_t led_dat_i,
    input  soc_pkg::byte_t prng_dat_i,
    input  soc_pkg::byte_t ram_dat_i,
    input  logic           rom_ack_i,
    input  logic           led_ack_i,
    input  logic           prng_ack_i,
    input  logic           ram_ack_i
);
    import soc_pkg::*;

    typedef enum logic [2:0] {SEL_RAM, SEL_ROM, SEL_LED, SEL_PRNG, SEL_RSV} sel_e;

    sel_e sel_d;
    sel_e sel_q;
    logic bus_stb;
    logic rsv_ack_q;

    function automatic logic hit(addr_t adr, addr_t base, addr_t mask);
        return (adr & mask) == base;
    endfunction

    // priority order, led and prng sit inside the reserved io range
    always_comb begin
        if (hit(wb_adr_i, LED_BASE, LED_MASK))
            sel_d = SEL_LED;
        else if (hit(wb_adr_i, PRNG_BASE, PRNG_MASK))
            sel_d = SEL_PRNG;
        else if (hit(wb_adr_i, ROM_BASE, ROM_MASK))
            sel_d = SEL_ROM;
        else if (hit(wb_adr_i, RSV_IO_BASE, RSV_IO_MASK) ||
                 hit(wb_adr_i, RSV_VIDEO_BASE, RSV_VIDEO_MASK))
            sel_d = SEL_RSV;
        else
            sel_d = SEL_RAM;
    end

    // single place where reset blocks the bus
    assign bus_stb    = wb_stb_i & ~sys_reset_i;
    assign rom_stb_o  = bus_stb && (sel_d == SEL_ROM);
    assign led_stb_o  = bus_stb && (sel_d == SEL_LED);
    assign prng_stb_o = bus_stb && (sel_d == SEL_PRNG);
    assign ram_stb_o  = bus_stb && (sel_d == SEL_RAM);

    always_ff @(posedge clk) begin
        if (sys_reset_i) begin
            sel_q     <= SEL_RSV;
            rsv_ack_q <= 1'b0;
        end else begin
            sel_q     <= sel_d;
            rsv_ack_q <= bus_stb && (sel_d == SEL_RSV);
        end
    end

    // return path follows the device that took last cycle's strobe
    always_comb begin
        case (sel_q)
            SEL_ROM:  {wb_dat_o, wb_ack_o} = {rom_dat_i, rom_ack_i};
            SEL_LED:  {wb_dat_o, wb_ack_o} = {led_dat_i, led_ack_i};
            SEL_PRNG: {wb_dat_o, wb_ack_o} = {prng_dat_i, prng_ack_i};
            SEL_RAM:  {wb_dat_o, wb_ack_o} = {ram_dat_i, ram_ack_i};
            default:  {wb_dat_o, wb_ack_o} = {8'h00, rsv_ack_q};
        endcase
    end

endmodule

//--- boot_rom.sv
`timescale 1ns/1ns

module boot_rom (
    input  logic       clk,
    input  logic       stb_i,
    input  logic [4:0] adr_i,
    output logic [7:0] dat_o,
    output logic       ack_o
);

    // depth follows the address port, so addresses wrap
    logic [7:0] rom_q [2**$bits(adr_i)];

    initial begin
        $readmemh("bootrom.hex", rom_q);
    end

    // no write enable here, writes just get acked
    always_ff @(posedge clk) begin
        if (stb_i) begin
            dat_o <= rom_q[adr_i];
        end
    end

    always_ff @(posedge clk) begin
        ack_o <= stb_i;
    end

endmodule

//--- led_register.sv
`timescale 1ns/1ns

module led_register (
    input  logic       clk,
    input  logic       sys_reset_i,
    input  logic       stb_i,
    input  logic       we_i,
    input  logic [7:0] dat_i,
    output logic [7:0] dat_o,
    output logic       ack_o,
    output logic [7:0] leds_o
);

    logic [7:0] leds_q;

    // leds must be dark right after reset
    always_ff @(posedge clk) begin
        if (sys_reset_i) begin
            leds_q <= 8'h00;
        end else if (stb_i && we_i) begin
            leds_q <= dat_i;
        end
    end

    always_ff @(posedge clk) begin
        ack_o <= stb_i;
        if (stb_i) begin
            dat_o <= leds_q;
        end
    end

    assign leds_o = leds_q;

endmodule

//--- block_ram.sv
`timescale 1ns/1ns

module block_ram (
    input  logic                                clk,
    input  logic                                stb_i,
    input  logic                                we_i,
    input  logic [soc_pkg::RAM_ADDR_BITS-1:0]   adr_i,
    input  soc_pkg::byte_t                      dat_i,
    output soc_pkg::byte_t                      dat_o,
    output logic                                ack_o
);
    import soc_pkg::*;

    byte_t mem_q [2**RAM_ADDR_BITS];

    // read-first, so a write strobe returns the old byte
    always_ff @(posedge clk) begin
        if (stb_i) begin
            if (we_i) begin
                mem_q[adr_i] <= dat_i;
            end
            dat_o <= mem_q[adr_i];
        end
    end

    // one cycle latency for every access
    always_ff @(posedge clk) begin
        ack_o <= stb_i;
    end

endmodule

//--- prng_lfsr.sv
`timescale 1ns/1ns

module prng_lfsr (
    input  logic           clk,
    input  logic           sys_reset_i,
    input  logic           stb_i,
    input  logic           we_i,
    input  logic           adr_i,
    input  soc_pkg::byte_t dat_i,
    output soc_pkg::byte_t dat_o,
    output logic           ack_o
);
    import soc_pkg::*;

    prng_state_t state_q;
    prng_state_t state_next;
    logic        feedback;

    // fibonacci form, shift left and feed the tap parity into bit 0
    assign feedback   = ^(state_q & PRNG_TAPS);
    assign state_next = {state_q[14:0], feedback};

    always_ff @(posedge clk) begin
        if (sys_reset_i) begin
            state_q <= PRNG_SEED_DEFAULT;
        end else if (stb_i && we_i) begin
            // seed one byte at a time
            if (adr_i) begin
                state_q[15:8] <= dat_i;
            end else begin
                state_q[7:0] <= dat_i;
            end
        end else if (stb_i && !adr_i) begin
            // only low byte reads step the generator
            state_q <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        ack_o <= stb_i;
        if (stb_i) begin
            dat_o <= adr_i ? state_q[15:8] : state_q[7:0];
        end
    end

endmodule

//--- soc_top.sv
`timescale 1ns/1ns

module soc_top (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           reset_button_n_i,
    input  logic           uart_rts_n_i,
    input  soc_pkg::addr_t wb_adr_i,
    input  soc_pkg::byte_t wb_dat_i,
    input  logic           wb_we_i,
    input  logic           wb_stb_i,
    output soc_pkg::byte_t wb_dat_o,
    output logic           wb_ack_o,
    output soc_pkg::byte_t leds_o,
    output logic           sys_reset_o
);
    import soc_pkg::*;

    logic  sys_reset;
    logic  rom_stb;
    logic  led_stb;
    logic  prng_stb;
    logic  ram_stb;
    byte_t rom_dat;
    byte_t led_dat;
    byte_t prng_dat;
    byte_t ram_dat;
    logic  rom_ack;
    logic  led_ack;
    logic  prng_ack;
    logic  ram_ack;

    assign sys_reset_o = sys_reset;

    reset_sequencer u_reset_sequencer (
        .clk              (clk),
        .reset_i          (reset_i),
        .reset_button_n_i (reset_button_n_i),
        .uart_rts_n_i     (uart_rts_n_i),
        .sys_reset_o      (sys_reset)
    );

    bus_address_decoder u_decoder (
        .clk         (clk),
        .sys_reset_i (sys_reset),
        .wb_adr_i    (wb_adr_i),
        .wb_stb_i    (wb_stb_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .rom_stb_o   (rom_stb),
        .led_stb_o   (led_stb),
        .prng_stb_o  (prng_stb),
        .ram_stb_o   (ram_stb),
        .rom_dat_i   (rom_dat),
        .led_dat_i   (led_dat),
        .prng_dat_i  (prng_dat),
        .ram_dat_i   (ram_dat),
        .rom_ack_i   (rom_ack),
        .led_ack_i   (led_ack),
        .prng_ack_i  (prng_ack),
        .ram_ack_i   (ram_ack)
    );

    boot_rom u_boot_rom (
        .clk   (clk),
        .stb_i (rom_stb),
        .adr_i (wb_adr_i[ROM_ADDR_BITS-1:0]),
        .dat_o (rom_dat),
        .ack_o (rom_ack)
    );

    led_register u_led_register (
        .clk         (clk),
        .sys_reset_i (sys_reset),
        .stb_i       (led_stb),
        .we_i        (wb_we_i),
        .dat_i       (wb_dat_i),
        .dat_o       (led_dat),
        .ack_o       (led_ack),
        .leds_o      (leds_o)
    );

    block_ram u_block_ram (
        .clk   (clk),
        .stb_i (ram_stb),
        .we_i  (wb_we_i),
        .adr_i (wb_adr_i[RAM_ADDR_BITS-1:0]),
        .dat_i (wb_dat_i),
        .dat_o (ram_dat),
        .ack_o (ram_ack)
    );

    prng_lfsr u_prng (
        .clk         (clk),
        .sys_reset_i (sys_reset),
        .stb_i       (prng_stb),
        .we_i        (wb_we_i),
        .adr_i       (wb_adr_i[0]),
        .dat_i       (wb_dat_i),
        .dat_o       (prng_dat),
        .ack_o       (prng_ack)
    );

endmodule

//--- soc_properties.sv
`timescale 1ns/1ns

module soc_properties (
    input logic           clk,
    input logic           sys_reset_o,
    input soc_pkg::addr_t wb_adr_i,
    input logic           wb_we_i,
    input logic           wb_stb_i,
    input logic           wb_ack_o,
    input soc_pkg::byte_t leds_o
);
    import soc_pkg::*;

    int unsigned assert_fail_cnt = 0;
    logic        led_write;

    assign led_write = wb_stb_i && wb_we_i && ((wb_adr_i & LED_MASK) == LED_BASE);

    // every accepted strobe gets its ack on the next clock
    ack_after_stb: assert property (@(posedge clk) (wb_stb_i && !sys_reset_o) |=> wb_ack_o)
        else begin
            assert_fail_cnt++;
            $error("bus ack missing one cycle after a strobe");
        end

    no_ack_in_reset: assert property (@(posedge clk) sys_reset_o |-> !wb_ack_o)
        else begin
            assert_fail_cnt++;
            $error("bus ack seen while system reset is high");
        end

    // the reset clear of the register happens while sys_reset_o is still high
    leds_on_write_only: assert property (@(posedge clk) disable iff (sys_reset_o)
        !$stable(leds_o) |-> $past(led_write && !sys_reset_o))
        else begin
            assert_fail_cnt++;
            $error("leds changed without a write to the led window");
        end

endmodule

bind soc_top soc_properties u_props (
    .clk         (clk),
    .sys_reset_o (sys_reset_o),
    .wb_adr_i    (wb_adr_i),
    .wb_we_i     (wb_we_i),
    .wb_stb_i    (wb_stb_i),
    .wb_ack_o    (wb_ack_o),
    .leds_o      (leds_o)
);

//--- tb_soc.sv
`timescale 1ns/1ns

module tb_soc;
    import soc_pkg::*;

    typedef enum logic [2:0] {OP_READ, OP_WRITE, OP_LEDS, OP_BUTTON, OP_RTS} op_e;

    typedef struct {
        string name;
        op_e   op;
        addr_t adr;
        byte_t dat;
        byte_t exp;
    } row_t;

    localparam int          CLK_PERIOD     = 4;
    localparam int          DRIVE_DELAY    = 1;
    localparam int          RESET_CYCLES   = 4;
    localparam int          ROW_BUDGET_NS  = 40;
    localparam logic [31:0] RNG_SEED       = 32'h51bf3db3;
    localparam addr_t       LED_ADR        = 32'hFFFF_FFF0;
    localparam addr_t       PRNG_ADR       = 32'hFFFF_FE00;
    // ram write attempted while the system reset is high
    localparam byte_t       HELD_WRITE_DAT = 8'hE7;
    // one probe per dropped device window
    localparam addr_t RSV_PROBES [10] = '{32'hFFFF_0000, 32'hFFFF_1FFF, 32'hFFFF_F800,
                                          32'hFFFF_F9A0, 32'hFFFF_FA11, 32'hFFFF_FB42,
                                          32'hFFFF_FC7E, 32'hFFFF_FD55, 32'hFFFF_FF00,
                                          32'hFFFF_FFE7};

    logic  clk;
    logic  reset_i;
    logic  reset_button_n_i;
    logic  uart_rts_n_i;
    addr_t wb_adr_i;
    byte_t wb_dat_i;
    logic  wb_we_i;
    logic  wb_stb_i;
    byte_t wb_dat_o;
    logic  wb_ack_o;
    byte_t leds_o;
    logic  sys_reset_o;

    row_t rows [$];
    bit   table_ready = 1'b0;
    int   watchdog_ns;

    soc_top DUT (
        .clk              (clk),
        .reset_i          (reset_i),
        .reset_button_n_i (reset_button_n_i),
        .uart_rts_n_i     (uart_rts_n_i),
        .wb_adr_i         (wb_adr_i),
        .wb_dat_i         (wb_dat_i),
        .wb_we_i          (wb_we_i),
        .wb_stb_i         (wb_stb_i),
        .wb_dat_o         (wb_dat_o),
        .wb_ack_o         (wb_ack_o),
        .leds_o           (leds_o),
        .sys_reset_o      (sys_reset_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED %s expected 0x%02h actual 0x%02h",
                                name, expected, actual));
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED %s expected %b actual %b", name, expected, actual));
        end
    endtask

    // rom image holds n xor 5a and wraps every ROM_WORDS bytes
    function automatic byte_t rom_byte(input int unsigned offset);
        return byte_t'(offset % ROM_WORDS) ^ 8'h5A;
    endfunction

    // fibonacci step with taps 15 13 12 10 shifted in at bit 0
    function automatic prng_state_t lfsr_next(input prng_state_t s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic push_row(input string name, input op_e op, input addr_t adr,
                            input byte_t dat, input byte_t exp);
        row_t r;
        r.name = name;
        r.op   = op;
        r.adr  = adr;
        r.dat  = dat;
        r.exp  = exp;
        rows.push_back(r);
    endtask

    task automatic build_table();
        byte_t       led_model;
        prng_state_t prng_model;
        byte_t       ram_model [4096];
        addr_t       ram_adr [$];
        addr_t       adr;
        byte_t       val;
        int unsigned k;
        int          n;
        led_model  = 8'h00;
        prng_model = PRNG_SEED_DEFAULT;
        // led register at several offsets in the window
        push_row("led write", OP_WRITE, LED_ADR, 8'hA5, 8'h00);
        led_model = 8'hA5;
        push_row("led pins", OP_LEDS, '0, 8'h00, led_model);
        push_row("led read offset 7", OP_READ, LED_ADR | 32'h7, 8'h00, led_model);
        push_row("led write offset 9", OP_WRITE, LED_ADR | 32'h9, 8'h3C, 8'h00);
        led_model = 8'h3C;
        push_row("led pins again", OP_LEDS, '0, 8'h00, led_model);
        push_row("led read offset f", OP_READ, LED_ADR | 32'hF, 8'h00, led_model);
        // boot rom image then wrapped offsets
        for (n = 0; n < ROM_WORDS; n++) begin
            push_row($sformatf("rom %0d", n), OP_READ, ROM_BASE + addr_t'(n), 8'h00, rom_byte(n));
        end
        for (n = 0; n < 6; n++) begin
            k = $urandom() % 2048;
            push_row($sformatf("rom wrap 0x%03h", k), OP_READ, ROM_BASE + addr_t'(k),
                     8'h00, rom_byte(k));
        end
        // block ram at random addresses below the device windows
        for (n = 0; n < 8; n++) begin
            adr = $urandom() & 32'h7FFF_FFFF;
            val = byte_t'($urandom());
            ram_adr.push_back(adr);
            ram_model[adr[11:0]] = val;
            push_row($sformatf("ram write 0x%08h", adr), OP_WRITE, adr, val, 8'h00);
        end
        for (n = 0; n < 8; n++) begin
            adr = ram_adr[n];
            push_row($sformatf("ram read 0x%08h", adr), OP_READ, adr, 8'h00,
                     ram_model[adr[11:0]]);
            adr = ($urandom() & 32'h7FFF_F000) | (ram_adr[n] & 32'h0000_0FFF);
            push_row($sformatf("ram wrap read 0x%08h", adr), OP_READ, adr, 8'h00,
                     ram_model[adr[11:0]]);
        end
        // generator from the reset seed
        for (n = 0; n < 6; n++) begin
            push_row($sformatf("prng step %0d", n), OP_READ, PRNG_ADR, 8'h00, prng_model[7:0]);
            prng_model = lfsr_next(prng_model);
        end
        push_row("prng high byte", OP_READ, PRNG_ADR | 32'h1, 8'h00, prng_model[15:8]);
        push_row("prng after high read", OP_READ, PRNG_ADR, 8'h00, prng_model[7:0]);
        prng_model = lfsr_next(prng_model);
        // odd low byte keeps the seed away from the all-zero lockup
        val = byte_t'($urandom()) | 8'h01;
        push_row("prng seed low", OP_WRITE, PRNG_ADR, val, 8'h00);
        prng_model[7:0] = val;
        val = byte_t'($urandom());
        push_row("prng seed high", OP_WRITE, PRNG_ADR | 32'h1, val, 8'h00);
        prng_model[15:8] = val;
        for (n = 0; n < 6; n++) begin
            push_row($sformatf("prng seeded step %0d", n), OP_READ, PRNG_ADR, 8'h00,
                     prng_model[7:0]);
            prng_model = lfsr_next(prng_model);
        end
        // reserved windows read zero and swallow writes
        for (n = 0; n < $size(RSV_PROBES); n++) begin
            push_row($sformatf("reserved read 0x%08h", RSV_PROBES[n]), OP_READ, RSV_PROBES[n],
                     8'h00, 8'h00);
        end
        push_row("ram guard f10", OP_WRITE, 32'h0000_0F10, 8'h6D, 8'h00);
        push_row("ram guard 000", OP_WRITE, 32'h0000_0000, 8'h17, 8'h00);
        push_row("reserved write ff10", OP_WRITE, 32'hFFFF_FF10, 8'h92, 8'h00);
        push_row("reserved write 0000", OP_WRITE, 32'hFFFF_0000, 8'hC8, 8'h00);
        push_row("reserved write ffe0", OP_WRITE, 32'hFFFF_FFE0, 8'h55, 8'h00);
        push_row("leds after reserved", OP_LEDS, '0, 8'h00, led_model);
        push_row("ram guard f10 kept", OP_READ, 32'h0000_0F10, 8'h00, 8'h6D);
        push_row("ram guard 000 kept", OP_READ, 32'h0000_0000, 8'h00, 8'h17);
        // reset sources restart the hold count, clear the devices and block the bus
        push_row("button pulse release", OP_BUTTON, 32'h0000_0F10, 8'd1,
                 byte_t'(RESET_HOLD_CYCLES));
        prng_model = PRNG_SEED_DEFAULT;
        push_row("ram f10 after held write", OP_READ, 32'h0000_0F10, 8'h00, 8'h6D);
        push_row("leds after button", OP_LEDS, '0, 8'h00, 8'h00);
        push_row("prng after button", OP_READ, PRNG_ADR, 8'h00, prng_model[7:0]);
        push_row("led write before rts", OP_WRITE, LED_ADR, 8'h81, 8'h00);
        push_row("rts pulse release", OP_RTS, 32'h0000_0000, 8'd3, byte_t'(RESET_HOLD_CYCLES));
        push_row("ram 000 after held write", OP_READ, 32'h0000_0000, 8'h00, 8'h17);
        push_row("leds after rts", OP_LEDS, '0, 8'h00, 8'h00);
        push_row("prng high after rts", OP_READ, PRNG_ADR | 32'h1, 8'h00, prng_model[15:8]);
    endtask

    // one strobe cycle and the return sampled a cycle later
    task automatic bus_access(input addr_t adr, input byte_t dat, input logic we,
                              output byte_t rd, output logic ack);
        @(posedge clk);
        #DRIVE_DELAY;
        wb_adr_i = adr;
        wb_dat_i = dat;
        wb_we_i  = we;
        wb_stb_i = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        rd       = wb_dat_o;
        ack      = wb_ack_o;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic pulse_source(input op_e op, input int cycles);
        @(posedge clk);
        #DRIVE_DELAY;
        if (op == OP_BUTTON) begin
            reset_button_n_i = 1'b0;
        end else begin
            uart_rts_n_i = 1'b0;
        end
        repeat (cycles) @(posedge clk);
        #DRIVE_DELAY;
        reset_button_n_i = 1'b1;
        uart_rts_n_i     = 1'b1;
    endtask

    // clocks from the last active source cycle until sys_reset_o drops
    task automatic count_release(output int cycles);
        cycles = 0;
        while (sys_reset_o && cycles < RESET_HOLD_CYCLES + 8) begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
        end
        if (sys_reset_o) begin
            abort_run("system reset was never released after the sources went idle");
        end
    endtask

    task automatic apply_row(input row_t r);
        byte_t rd;
        logic  ack;
        int    cycles;
        case (r.op)
            OP_READ, OP_WRITE: begin
                bus_access(r.adr, r.dat, r.op == OP_WRITE, rd, ack);
                check_bit($sformatf("%s ack", r.name), 1'b1, ack);
                if (r.op == OP_READ) begin
                    check_byte(r.name, r.exp, rd);
                end
            end
            OP_LEDS: begin
                @(posedge clk);
                #DRIVE_DELAY;
                check_byte(r.name, r.exp, leds_o);
            end
            default: begin
                pulse_source(r.op, int'(r.dat));
                check_bit($sformatf("%s asserted", r.name), 1'b1, sys_reset_o);
                // a ram write during reset must be dropped without an ack
                bus_access(r.adr, HELD_WRITE_DAT, 1'b1, rd, ack);
                check_bit($sformatf("%s ack in reset", r.name), 1'b0, ack);
                count_release(cycles);
                // the blocked write took two of the hold cycles
                check_byte(r.name, r.exp, byte_t'(cycles + 2));
            end
        endcase
    endtask

    initial begin
        wait (table_ready);
        #(watchdog_ns);
        abort_run("watchdog expired, the bus test hung");
    end

    initial begin
        int cycles;
        reset_i          = 1'b1;
        reset_button_n_i = 1'b1;
        uart_rts_n_i     = 1'b1;
        wb_adr_i         = '0;
        wb_dat_i         = '0;
        wb_we_i          = 1'b0;
        wb_stb_i         = 1'b0;
        void'($urandom(RNG_SEED));
        build_table();
        watchdog_ns = rows.size() * ROW_BUDGET_NS + (RESET_CYCLES + RESET_HOLD_CYCLES) * CLK_PERIOD;
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset_i = 1'b0;
        count_release(cycles);
        check_byte("power-on release", byte_t'(RESET_HOLD_CYCLES), byte_t'(cycles));
        check_byte("power-on leds", 8'h00, leds_o);
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        if (DUT.u_props.assert_fail_cnt == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            abort_run($sformatf("%0d bus property violations", DUT.u_props.assert_fail_cnt));
        end
    end

endmodule

//--- bootrom.hex
// boot rom image, one hex byte per line, address 0 first
5a
5b
58
59
5e
5f
5c
5d
52
53
50
51
56
57
54
55
4a
4b
48
49
4e
4f
4c
4d
42
43
40
41
46
47
44
45

//--- flist.f
soc_pkg.sv
reset_sequencer.sv
bus_address_decoder.sv
boot_rom.sv
led_register.sv
block_ram.sv
prng_lfsr.sv
soc_top.sv
soc_properties.sv
tb_soc.sv

//--- run.sh
#!/bin/sh
# builds the soc testbench with verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_soc -o tb_soc_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_soc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
